/* source/execPkg.sv */
package execPkg;

	// integer datapath width fixed by the instruction set
	localparam int dataWidth = 32;

	// alu operation from the main decoder
	typedef enum logic [2:0] {
		opAdd   = 3'b000,
		opSub   = 3'b001,
		opRType = 3'b010,
		// sltiu has its own code apart from ori
		opSltu  = 3'b011,
		opAnd   = 3'b100,
		opOr    = 3'b101,
		opSlt   = 3'b110,
		opXor   = 3'b111
	} aluOpE;

	// alu control codes
	typedef enum logic [4:0] {
		ctlAnd     = 5'd0,
		ctlOr      = 5'd1,
		ctlAdd     = 5'd2,
		ctlDiv     = 5'd3,
		ctlDivu    = 5'd4,
		ctlXor     = 5'd5,
		ctlSub     = 5'd6,
		ctlSlt     = 5'd7,
		ctlSltu    = 5'd8,
		ctlSll     = 5'd9,
		ctlSrl     = 5'd10,
		ctlMult    = 5'd11,
		ctlMultu   = 5'd12,
		ctlSllv    = 5'd13,
		ctlSrlv    = 5'd14,
		ctlSra     = 5'd15,
		ctlSrav    = 5'd16,
		ctlInvalid = 5'd31
	} aluCtlE;

	// r-type function field values
	localparam logic [5:0] functSll   = 6'b000000;
	localparam logic [5:0] functSrl   = 6'b000010;
	localparam logic [5:0] functSra   = 6'b000011;
	localparam logic [5:0] functSllv  = 6'b000100;
	localparam logic [5:0] functSrlv  = 6'b000110;
	localparam logic [5:0] functSrav  = 6'b000111;
	localparam logic [5:0] functMult  = 6'b011000;
	localparam logic [5:0] functMultu = 6'b011001;
	localparam logic [5:0] functDiv   = 6'b011010;
	localparam logic [5:0] functDivu  = 6'b011011;
	localparam logic [5:0] functAddu  = 6'b100001;
	localparam logic [5:0] functSubu  = 6'b100011;
	localparam logic [5:0] functAnd   = 6'b100100;
	localparam logic [5:0] functOr    = 6'b100101;
	localparam logic [5:0] functXor   = 6'b100110;
	localparam logic [5:0] functSlt   = 6'b101010;
	localparam logic [5:0] functSltu  = 6'b101011;

	// register format
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	// immediate format
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeT;

	// one instruction word read as either field layout
	typedef union packed {
		rTypeT rType;
		iTypeT iType;
	} instrU;

	// decoded control for the execute stage
	typedef struct packed {
		aluCtlE ctl;
		logic   useImm;
		logic   zeroExt;
		logic   isMulDiv;
	} aluCtrlT;

endpackage

/* source/aluControl.sv */
`timescale 1ns/1ps

module aluControl (
	input  execPkg::aluOpE   aluOp,
	input  logic [5:0]       functCode,
	output execPkg::aluCtrlT aluCtrl
);

	execPkg::aluCtlE ctl;
	logic            useImm;
	logic            zeroExt;

	always_comb begin
		// defaults for the immediate group
		useImm  = 1'b1;
		zeroExt = 1'b0;
		ctl     = execPkg::ctlInvalid;
		case (aluOp)
			// loads, stores, addiu
			execPkg::opAdd: ctl = execPkg::ctlAdd;
			// branch compare
			execPkg::opSub: ctl = execPkg::ctlSub;
			// andi
			execPkg::opAnd: begin
				ctl     = execPkg::ctlAnd;
				zeroExt = 1'b1;
			end
			// ori
			execPkg::opOr: begin
				ctl     = execPkg::ctlOr;
				zeroExt = 1'b1;
			end
			// xori
			execPkg::opXor: begin
				ctl     = execPkg::ctlXor;
				zeroExt = 1'b1;
			end
			// slti
			execPkg::opSlt: ctl = execPkg::ctlSlt;
			// sltiu, immediate still sign extended
			execPkg::opSltu: ctl = execPkg::ctlSltu;
			execPkg::opRType: begin
				// register operands only
				useImm = 1'b0;
				case (functCode)
					execPkg::functAddu:  ctl = execPkg::ctlAdd;
					execPkg::functSubu:  ctl = execPkg::ctlSub;
					execPkg::functDiv:   ctl = execPkg::ctlDiv;
					execPkg::functDivu:  ctl = execPkg::ctlDivu;
					execPkg::functMult:  ctl = execPkg::ctlMult;
					execPkg::functMultu: ctl = execPkg::ctlMultu;
					execPkg::functAnd:   ctl = execPkg::ctlAnd;
					execPkg::functOr:    ctl = execPkg::ctlOr;
					execPkg::functXor:   ctl = execPkg::ctlXor;
					execPkg::functSlt:   ctl = execPkg::ctlSlt;
					execPkg::functSltu:  ctl = execPkg::ctlSltu;
					execPkg::functSll:   ctl = execPkg::ctlSll;
					execPkg::functSrl:   ctl = execPkg::ctlSrl;
					execPkg::functSllv:  ctl = execPkg::ctlSllv;
					execPkg::functSrlv:  ctl = execPkg::ctlSrlv;
					execPkg::functSra:   ctl = execPkg::ctlSra;
					execPkg::functSrav:  ctl = execPkg::ctlSrav;
					// unknown funct flagged downstream
					default:             ctl = execPkg::ctlInvalid;
				endcase
			end
			default: ctl = execPkg::ctlInvalid;
		endcase
	end

	always_comb begin
		aluCtrl.ctl     = ctl;
		aluCtrl.useImm  = useImm;
		aluCtrl.zeroExt = zeroExt;
		// these go to the iterative unit
		aluCtrl.isMulDiv = (ctl == execPkg::ctlDiv) || (ctl == execPkg::ctlDivu) ||
			(ctl == execPkg::ctlMult) || (ctl == execPkg::ctlMultu);
	end

endmodule

/* source/aluCore.sv */
`timescale 1ns/1ps

module aluCore (
	input  execPkg::aluCtrlT               aluCtrl,
	input  execPkg::instrU                 instr,
	input  logic [execPkg::dataWidth-1:0]  rsData,
	input  logic [execPkg::dataWidth-1:0]  rtData,
	output logic [execPkg::dataWidth-1:0]  result,
	output logic                           zero,
	output logic                           invalidOp
);

	logic [execPkg::dataWidth-1:0] immExt;
	logic [execPkg::dataWidth-1:0] opB;
	logic [4:0]                    shamt;
	logic [4:0]                    varShamt;
	logic [15:0]                   imm;
	logic                          sltSigned;
	logic                          sltUnsigned;

	// immediate read through the i-type view
	assign imm = instr.iType.imm;

	// shift amounts
	assign shamt    = instr.rType.shamt;
	assign varShamt = rsData[4:0];

	// logic immediates are zero extended, the rest sign extended
	always_comb begin
		if (aluCtrl.zeroExt) begin
			immExt = {16'b0, imm};
		end else begin
			immExt = {{16{imm[15]}}, imm};
		end
	end

	// second operand select
	assign opB = aluCtrl.useImm ? immExt : rtData;

	// compares against the selected operand
	assign sltSigned   = $signed(rsData) < $signed(opB);
	assign sltUnsigned = rsData < opB;

	always_comb begin
		result = '0;
		case (aluCtrl.ctl)
			execPkg::ctlAnd:  result = rsData & opB;
			execPkg::ctlOr:   result = rsData | opB;
			execPkg::ctlXor:  result = rsData ^ opB;
			// no overflow detection
			execPkg::ctlAdd:  result = rsData + opB;
			execPkg::ctlSub:  result = rsData - opB;
			execPkg::ctlSlt:  result = {31'b0, sltSigned};
			execPkg::ctlSltu: result = {31'b0, sltUnsigned};
			// fixed shifts act on rt by shamt
			execPkg::ctlSll:  result = rtData << shamt;
			execPkg::ctlSrl:  result = rtData >> shamt;
			execPkg::ctlSra:  result = $signed(rtData) >>> shamt;
			// variable shifts use low bits of rs
			execPkg::ctlSllv: result = rtData << varShamt;
			execPkg::ctlSrlv: result = rtData >> varShamt;
			execPkg::ctlSrav: result = $signed(rtData) >>> varShamt;
			// mult and div results land in hi and lo instead
			default:          result = '0;
		endcase
	end

	assign invalidOp = (aluCtrl.ctl == execPkg::ctlInvalid);

	// branch compare flag
	assign zero = (result == '0);

endmodule

/* source/mulDivUnit.sv */
`timescale 1ns/1ps

module mulDivUnit (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic                           issue,
	input  execPkg::aluCtrlT               aluCtrl,
	input  logic [execPkg::dataWidth-1:0]  rsData,
	input  logic [execPkg::dataWidth-1:0]  rtData,
	output logic [execPkg::dataWidth-1:0]  hi,
	output logic [execPkg::dataWidth-1:0]  lo,
	output logic                           mdBusy
);

	localparam int w = execPkg::dataWidth;

	logic         start;
	logic         isSigned;
	logic         isDivOp;
	logic [w-1:0] magA;
	logic [w-1:0] magB;
	logic [4:0]   stepCnt;
	logic         lastStep;

	// working registers shared by both ops
	logic [w-1:0] accHi;
	logic [w-1:0] accLo;
	logic [w-1:0] opB;
	logic         isDiv;
	logic         negHi;
	logic         negLo;

	// next state of one step
	logic [w:0]     mulSum;
	logic [w:0]     divShift;
	logic [w:0]     divDiff;
	logic [w-1:0]   nextHi;
	logic [w-1:0]   nextLo;
	logic [2*w-1:0] prodFull;
	logic [w-1:0]   finHi;
	logic [w-1:0]   finLo;

	// busy issues are dropped
	assign start = issue && aluCtrl.isMulDiv && !mdBusy;

	assign isSigned = (aluCtrl.ctl == execPkg::ctlMult) || (aluCtrl.ctl == execPkg::ctlDiv);
	assign isDivOp  = (aluCtrl.ctl == execPkg::ctlDiv) || (aluCtrl.ctl == execPkg::ctlDivu);

	// operand magnitudes where min int maps onto itself
	assign magA = (isSigned && rsData[w-1]) ? -rsData : rsData;
	assign magB = (isSigned && rtData[w-1]) ? -rtData : rtData;

	assign lastStep = (stepCnt == 5'd31);

	always_comb begin
		// multiply adds the multiplicand when the low bit is set
		mulSum = {1'b0, accHi} + (accLo[0] ? {1'b0, opB} : '0);
		// restoring divide shifts in the next dividend bit
		divShift = {accHi, accLo[w-1]};
		divDiff  = divShift - {1'b0, opB};
		if (isDiv) begin
			if (!divDiff[w]) begin
				// divisor fits so keep difference and set quotient bit
				nextHi = divDiff[w-1:0];
				nextLo = {accLo[w-2:0], 1'b1};
			end else begin
				// restore
				nextHi = divShift[w-1:0];
				nextLo = {accLo[w-2:0], 1'b0};
			end
		end else begin
			nextHi = mulSum[w:1];
			nextLo = {mulSum[0], accLo[w-1:1]};
		end
	end

	// sign fixup on the final step
	always_comb begin
		prodFull = {nextHi, nextLo};
		if (negLo) begin
			prodFull = -prodFull;
		end
		if (isDiv) begin
			// quotient toward zero and remainder with the dividend sign
			finLo = negLo ? -nextLo : nextLo;
			finHi = negHi ? -nextHi : nextHi;
		end else begin
			finLo = prodFull[w-1:0];
			finHi = prodFull[2*w-1:w];
		end
	end

	// control and result registers
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mdBusy  <= 1'b0;
			stepCnt <= '0;
			hi      <= '0;
			lo      <= '0;
		end else if (start) begin
			mdBusy  <= 1'b1;
			stepCnt <= '0;
		end else if (mdBusy) begin
			stepCnt <= stepCnt + 5'd1;
			if (lastStep) begin
				mdBusy <= 1'b0;
				hi     <= finHi;
				lo     <= finLo;
			end
		end
	end

	// datapath registers
	always_ff @(posedge clk) begin
		if (start) begin
			isDiv <= isDivOp;
			opB   <= magB;
			// multiplier or dividend goes into the low half
			accHi <= '0;
			accLo <= magA;
			// product or quotient sign
			negLo <= isSigned && (rsData[w-1] ^ rtData[w-1]);
			// remainder sign follows the dividend on divide only
			negHi <= isDivOp && isSigned && rsData[w-1];
		end else if (mdBusy) begin
			accHi <= nextHi;
			accLo <= nextLo;
		end
	end

endmodule

/* source/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic                           issue,
	input  execPkg::aluOpE                 aluOp,
	input  execPkg::instrU                 instr,
	input  logic [execPkg::dataWidth-1:0]  rsData,
	input  logic [execPkg::dataWidth-1:0]  rtData,
	output logic [execPkg::dataWidth-1:0]  result,
	output logic                           zero,
	output logic                           invalidOp,
	output logic [execPkg::dataWidth-1:0]  hi,
	output logic [execPkg::dataWidth-1:0]  lo,
	output logic                           mdBusy
);

	// decoded control shared by both units
	execPkg::aluCtrlT aluCtrl;

	aluControl aluControl_i (
		.aluOp     (aluOp),
		.functCode (instr.rType.funct),
		.aluCtrl   (aluCtrl)
	);

	// single cycle path
	aluCore aluCore_i (
		.aluCtrl   (aluCtrl),
		.instr     (instr),
		.rsData    (rsData),
		.rtData    (rtData),
		.result    (result),
		.zero      (zero),
		.invalidOp (invalidOp)
	);

	// 32 cycle multiply and divide
	mulDivUnit mulDivUnit_i (
		.clk     (clk),
		.arstN   (arstN),
		.issue   (issue),
		.aluCtrl (aluCtrl),
		.rsData  (rsData),
		.rtData  (rtData),
		.hi      (hi),
		.lo      (lo),
		.mdBusy  (mdBusy)
	);

endmodule

/* dv/refModel.svh */
`ifndef refModelSvh
`define refModelSvh

// one stimulus row with its expected response
typedef struct {
	string          name;
	execPkg::aluOpE aluOp;
	logic [5:0]     funct;
	logic [4:0]     shamt;
	logic [15:0]    imm;
	logic [31:0]    rsData;
	logic [31:0]    rtData;
	logic [31:0]    expResult;
	logic           expInvalid;
	logic           isMd;
	logic           disturb;
	logic [31:0]    expHi;
	logic [31:0]    expLo;
} entryT;

entryT       tests[$];
logic [31:0] lfsrState = 32'ha2b8;
// hi and lo as the model expects them after each row
logic [31:0] modelHi = '0;
logic [31:0] modelLo = '0;

// galois lfsr, taps x^32 + x^22 + x^2 + x + 1
function automatic logic lfsrBit();
	logic outBit;
	outBit = lfsrState[0];
	lfsrState = {1'b0, lfsrState[31:1]} ^ (outBit ? 32'h8020_0003 : 32'h0);
	return outBit;
endfunction

// n fresh bits, right aligned
function automatic logic [31:0] randBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsrBit()};
	end
	return v;
endfunction

// single cycle result straight from the instruction semantics
function automatic logic [31:0] expectedAlu(input execPkg::aluOpE op, input logic [5:0] funct,
	input logic [4:0] shamt, input logic [15:0] imm, input logic [31:0] a,
	input logic [31:0] b, output logic bad);
	logic [31:0] sx;
	logic [31:0] zx;
	sx = {{16{imm[15]}}, imm};
	zx = {16'h0, imm};
	bad = 1'b0;
	case (op)
		execPkg::opAdd:  return a + sx;
		execPkg::opSub:  return a - sx;
		// logic immediates use zero extension
		execPkg::opAnd:  return a & zx;
		execPkg::opOr:   return a | zx;
		execPkg::opXor:  return a ^ zx;
		execPkg::opSlt:  return {31'b0, $signed(a) < $signed(sx)};
		execPkg::opSltu: return {31'b0, a < sx};
		execPkg::opRType: begin
			case (funct)
				execPkg::functAddu: return a + b;
				execPkg::functSubu: return a - b;
				execPkg::functAnd:  return a & b;
				execPkg::functOr:   return a | b;
				execPkg::functXor:  return a ^ b;
				execPkg::functSlt:  return {31'b0, $signed(a) < $signed(b)};
				execPkg::functSltu: return {31'b0, a < b};
				execPkg::functSll:  return b << shamt;
				execPkg::functSrl:  return b >> shamt;
				execPkg::functSra:  return $signed(b) >>> shamt;
				execPkg::functSllv: return b << a[4:0];
				execPkg::functSrlv: return b >> a[4:0];
				execPkg::functSrav: return $signed(b) >>> a[4:0];
				// hi and lo carry these, result stays 0
				execPkg::functMult, execPkg::functMultu,
				execPkg::functDiv, execPkg::functDivu: return '0;
				default: bad = 1'b1;
			endcase
		end
		default: bad = 1'b1;
	endcase
	return '0;
endfunction

// {hi, lo} after a multiply or divide
function automatic logic [63:0] expectedMulDiv(input logic [5:0] funct, input logic [31:0] a,
	input logic [31:0] b);
	logic signed [63:0] sa;
	logic signed [63:0] sb;
	logic [31:0]        ma;
	logic [31:0]        mb;
	logic [31:0]        q;
	logic [31:0]        r;
	sa = {{32{a[31]}}, a};
	sb = {{32{b[31]}}, b};
	case (funct)
		execPkg::functMult:  return sa * sb;
		execPkg::functMultu: return {32'h0, a} * {32'h0, b};
		execPkg::functDivu:  return (b == '0) ? {a, 32'hffff_ffff} : {a % b, a / b};
		default: begin
			// magnitudes first, zero divisor as unsigned
			ma = a[31] ? -a : a;
			mb = b[31] ? -b : b;
			q = (mb == '0) ? 32'hffff_ffff : ma / mb;
			r = (mb == '0) ? ma : ma % mb;
			// quotient toward zero, remainder keeps dividend sign
			if (a[31] ^ b[31]) begin
				q = -q;
			end
			if (a[31]) begin
				r = -r;
			end
			return {r, q};
		end
	endcase
endfunction

// append one row, tracking hi and lo across rows
task automatic addEntry(input string name, input execPkg::aluOpE op, input logic [5:0] funct,
	input logic [4:0] shamt, input logic [15:0] imm, input logic [31:0] a,
	input logic [31:0] b, input logic disturb);
	entryT       e;
	logic        bad;
	logic [63:0] hiLo;
	e.name = name;
	e.aluOp = op;
	e.funct = funct;
	e.shamt = shamt;
	e.imm = imm;
	e.rsData = a;
	e.rtData = b;
	e.disturb = disturb;
	e.expResult = expectedAlu(op, funct, shamt, imm, a, b, bad);
	e.expInvalid = bad;
	e.isMd = (op == execPkg::opRType) && (funct inside {execPkg::functMult,
		execPkg::functMultu, execPkg::functDiv, execPkg::functDivu});
	if (e.isMd) begin
		hiLo = expectedMulDiv(funct, a, b);
		modelHi = hiLo[63:32];
		modelLo = hiLo[31:0];
	end
	e.expHi = modelHi;
	e.expLo = modelLo;
	tests.push_back(e);
endtask

`endif

/* dv/executeStageTb.sv */
`timescale 1ns/1ps

module executeStageTb;

	logic           clk;
	logic           arstN;
	logic           issue;
	execPkg::aluOpE aluOp;
	execPkg::instrU instr;
	logic [31:0]    rsData;
	logic [31:0]    rtData;
	logic [31:0]    result;
	logic           zero;
	logic           invalidOp;
	logic [31:0]    hi;
	logic [31:0]    lo;
	logic           mdBusy;
	logic           tableReady = 1'b0;

	`include "refModel.svh"

	executeStage executeStage_i (
		.clk       (clk),
		.arstN     (arstN),
		.issue     (issue),
		.aluOp     (aluOp),
		.instr     (instr),
		.rsData    (rsData),
		.rtData    (rtData),
		.result    (result),
		.zero      (zero),
		.invalidOp (invalidOp),
		.hi        (hi),
		.lo        (lo),
		.mdBusy    (mdBusy)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic checkValue(input string name, input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s %s expected %h actual %h", name, what, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// corners plus lfsr operands for every op
	task automatic buildTable();
		execPkg::aluOpE iOps[7];
		logic [5:0]     rFuncts[13];
		logic [5:0]     mdFuncts[4];
		logic [31:0]    a;
		logic [31:0]    b;
		logic [31:0]    r;
		iOps = '{execPkg::opAdd, execPkg::opSub, execPkg::opAnd, execPkg::opOr,
			execPkg::opXor, execPkg::opSlt, execPkg::opSltu};
		rFuncts = '{execPkg::functAddu, execPkg::functSubu, execPkg::functAnd,
			execPkg::functOr, execPkg::functXor, execPkg::functSlt, execPkg::functSltu,
			execPkg::functSll, execPkg::functSrl, execPkg::functSra, execPkg::functSllv,
			execPkg::functSrlv, execPkg::functSrav};
		mdFuncts = '{execPkg::functMult, execPkg::functMultu, execPkg::functDiv,
			execPkg::functDivu};
		foreach (iOps[k]) begin
			// 8001 splits sign and zero extension
			addEntry($sformatf("%s imm corner", iOps[k].name()), iOps[k], 6'h0, 5'h0,
				16'h8001, 32'h7fff_fffe, 32'h0, 1'b0);
			for (int n = 0; n < 3; n++) begin
				a = randBits(32);
				r = randBits(16);
				addEntry($sformatf("%s imm rand %0d", iOps[k].name(), n), iOps[k], 6'h0, 5'h0,
					r[15:0], a, 32'h0, 1'b0);
			end
		end
		addEntry("sub imm to zero", execPkg::opSub, 6'h0, 5'h0, 16'hfff0, 32'hffff_fff0, 32'h0,
			1'b0);
		foreach (rFuncts[k]) begin
			addEntry($sformatf("funct %02h corner 0", rFuncts[k]), execPkg::opRType, rFuncts[k],
				5'd31, 16'h0, 32'h8000_0000, 32'hffff_ffff, 1'b0);
			addEntry($sformatf("funct %02h corner 1", rFuncts[k]), execPkg::opRType, rFuncts[k],
				5'd1, 16'h0, 32'h7fff_ffff, 32'h0000_0001, 1'b0);
			for (int n = 0; n < 2; n++) begin
				a = randBits(32);
				b = randBits(32);
				r = randBits(5);
				addEntry($sformatf("funct %02h rand %0d", rFuncts[k], n), execPkg::opRType,
					rFuncts[k], r[4:0], 16'h0, a, b, 1'b0);
			end
		end
		addEntry("subu equal", execPkg::opRType, execPkg::functSubu, 5'd0, 16'h0, 32'h1234_5678,
			32'h1234_5678, 1'b0);
		// jr and an unused code
		addEntry("funct 08 invalid", execPkg::opRType, 6'h08, 5'd0, 16'h0, 32'h5, 32'h6, 1'b0);
		addEntry("funct 3f invalid", execPkg::opRType, 6'h3f, 5'd0, 16'h0, 32'h5, 32'h6, 1'b0);
		addEntry("multu max", execPkg::opRType, execPkg::functMultu, 5'd0, 16'h0, 32'hffff_ffff,
			32'hffff_ffff, 1'b0);
		addEntry("mult neg", execPkg::opRType, execPkg::functMult, 5'd0, 16'h0, 32'hffff_ffff,
			32'h5, 1'b0);
		addEntry("mult min", execPkg::opRType, execPkg::functMult, 5'd0, 16'h0, 32'h8000_0000,
			32'h8000_0000, 1'b0);
		addEntry("div neg dividend", execPkg::opRType, execPkg::functDiv, 5'd0, 16'h0,
			32'hffff_fff9, 32'h2, 1'b0);
		addEntry("div neg divisor", execPkg::opRType, execPkg::functDiv, 5'd0, 16'h0, 32'h7,
			32'hffff_fffe, 1'b0);
		addEntry("div both neg", execPkg::opRType, execPkg::functDiv, 5'd0, 16'h0,
			32'hffff_fff9, 32'hffff_fffe, 1'b0);
		addEntry("div min by minus one", execPkg::opRType, execPkg::functDiv, 5'd0, 16'h0,
			32'h8000_0000, 32'hffff_ffff, 1'b0);
		addEntry("div zero neg", execPkg::opRType, execPkg::functDiv, 5'd0, 16'h0,
			32'hffff_fff9, 32'h0, 1'b0);
		addEntry("div zero pos", execPkg::opRType, execPkg::functDiv, 5'd0, 16'h0, 32'h7, 32'h0,
			1'b0);
		addEntry("divu zero", execPkg::opRType, execPkg::functDivu, 5'd0, 16'h0, 32'h1234_5678,
			32'h0, 1'b0);
		addEntry("divu big", execPkg::opRType, execPkg::functDivu, 5'd0, 16'h0, 32'hffff_ffff,
			32'h8000_0001, 1'b0);
		foreach (mdFuncts[k]) begin
			a = randBits(32);
			b = randBits(32);
			addEntry($sformatf("md %02h rand", mdFuncts[k]), execPkg::opRType, mdFuncts[k], 5'd0,
				16'h0, a, b, 1'b0);
		end
		a = randBits(32);
		b = randBits(32);
		addEntry("mult reissue while busy", execPkg::opRType, execPkg::functMult, 5'd0, 16'h0,
			a, b, 1'b1);
		// hi and lo must hold through a plain add
		addEntry("add after md", execPkg::opAdd, 6'h0, 5'd0, 16'h0001, 32'h41, 32'h0, 1'b0);
	endtask

	// drive one row 2 ns after the edge, wait out any mult or div
	task automatic applyEntry(input entryT e);
		int cycles;
		instr = '0;
		if (e.aluOp == execPkg::opRType) begin
			instr.rType.shamt = e.shamt;
			instr.rType.funct = e.funct;
		end else begin
			instr.iType.imm = e.imm;
		end
		aluOp = e.aluOp;
		rsData = e.rsData;
		rtData = e.rtData;
		issue = 1'b1;
		// combinational outputs sampled mid cycle
		#8;
		checkValue(e.name, "result", e.expResult, result);
		checkValue(e.name, "zero", {31'b0, e.expResult == '0}, {31'b0, zero});
		checkValue(e.name, "invalidOp", {31'b0, e.expInvalid}, {31'b0, invalidOp});
		@(posedge clk);
		#2;
		issue = 1'b0;
		cycles = 0;
		checkValue(e.name, "mdBusy", {31'b0, e.isMd}, {31'b0, mdBusy});
		while (mdBusy) begin
			if (e.disturb && cycles == 4) begin
				// second mult that must be ignored
				issue = 1'b1;
				rsData = ~e.rsData;
				rtData = e.rtData + 32'd3;
			end else begin
				issue = 1'b0;
				rsData = e.rsData;
				rtData = e.rtData;
			end
			@(posedge clk);
			#2;
			cycles++;
		end
		issue = 1'b0;
		if (e.isMd) begin
			checkValue(e.name, "busy cycles", 32'd32, 32'(cycles));
		end
		checkValue(e.name, "hi", e.expHi, hi);
		checkValue(e.name, "lo", e.expLo, lo);
	endtask

	initial begin
		arstN = 1'b0;
		issue = 1'b0;
		aluOp = execPkg::opAdd;
		instr = '0;
		rsData = '0;
		rtData = '0;
		buildTable();
		tableReady = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		arstN = 1'b1;
		checkValue("reset", "hi", 32'h0, hi);
		checkValue("reset", "lo", 32'h0, lo);
		checkValue("reset", "mdBusy", 32'h0, {31'b0, mdBusy});
		foreach (tests[i]) begin
			applyEntry(tests[i]);
		end
		$display("STATUS: PASS");
		$finish;
	end

	// 40 cycles per row covers the longest divide
	initial begin
		wait (tableReady);
		repeat (tests.size() * 40 + 100) @(posedge clk);
		$display("timeout: the tests did not finish in %0d cycles", tests.size() * 40 + 100);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

/* sources.f */
+incdir+dv
source/execPkg.sv
source/aluControl.sv
source/aluCore.sv
source/mulDivUnit.sv
source/executeStage.sv
dv/executeStageTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= executeStageTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= STATUS: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) dv/refModel.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
